/* hdl/ntsc_pkg.sv */
`default_nettype none

package ntsc_pkg;

	// bus widths
	localparam int LUMA_W   = 9;	// luma in, 512 steps
	localparam int COLOR_W  = 4;	// one bit per chroma direction
	localparam int COORD_W  = 10;	// counters and pixel coordinates
	localparam int OUT_W    = 10;	// dac word
	localparam int CHROMA_W = 9;	// scaled subcarrier, signed
	localparam int PHASE_W  = 20;	// dds accumulator

	// 50 MHz / 5 gives the 100 ns pixel tick
	localparam logic [2:0] TICK_DIV = 3'd5;

	// horizontal counts, each value is the last tick of its segment
	localparam logic [COORD_W-1:0] H_SYNC_END   = 10'd46;	// 4.7 us sync tip
	localparam logic [COORD_W-1:0] H_BP1_END    = 10'd57;	// breezeway
	localparam logic [COORD_W-1:0] H_BURST_END  = 10'd82;	// ~9 cycles of burst
	localparam logic [COORD_W-1:0] H_BP2_END    = 10'd93;
	localparam logic [COORD_W-1:0] X_OFFSET     = 10'd94;	// first visible tick
	localparam logic [COORD_W-1:0] H_ACTIVE_END = 10'd619;	// 526 visible ticks
	localparam logic [COORD_W-1:0] H_TOTAL      = 10'd634;	// 63.5 us line

	// vertical, non-interlaced, 20 lines of blanking after the picture
	localparam logic [COORD_W-1:0] Y_RES       = 10'd240;
	localparam logic [COORD_W-1:0] Y_OFFSET    = 10'd17;	// top lines hidden by overscan
	localparam logic [COORD_W-1:0] LINE_LAST   = Y_RES + 10'd19;
	localparam logic [COORD_W-1:0] VSYNC_FIRST = Y_RES + 10'd6;
	localparam logic [COORD_W-1:0] VSYNC_LAST  = Y_RES + 10'd8;

	// output levels, 205 units ~ 40 IRE
	localparam logic [OUT_W-1:0] SYNC_LEVEL  = 10'd0;	// -40 IRE
	localparam logic [OUT_W-1:0] BLANK_LEVEL = 10'd205;	// 0 IRE
	localparam logic [OUT_W-1:0] BLACK_LEVEL = 10'd256;	// luma adds on top

	// 3.579545 MHz * 2^20 / 50 MHz = 75068.5
	localparam logic [PHASE_W-1:0] PHASE_STEP = 20'd75069;

	// saturation, 127 * 205 / 256 ~ 102 units peak
	localparam logic [7:0] COLOR_SCALE = 8'd205;

	// segment of the current line, in horizontal order
	typedef enum logic [2:0] {
		SEG_HSYNC,
		SEG_PORCH_A,
		SEG_BURST,
		SEG_PORCH_B,
		SEG_ACTIVE,
		SEG_FRONT
	} line_seg_e;

	// what the current line carries
	typedef enum logic [1:0] {
		LINE_ACTIVE,
		LINE_BLANK,
		LINE_VSYNC
	} line_kind_e;

endpackage

`default_nettype wire

/* hdl/raster_timing.sv */
`default_nettype none

module raster_timing (
	input  logic                          clock_in,
	input  logic                          rst_n,
	output logic                          pixel_tick,	// one clock in five
	output ntsc_pkg::line_seg_e           seg,
	output ntsc_pkg::line_kind_e          kind,
	output logic                          pixel_req,	// strobe, pixel at x/y wanted
	output logic [ntsc_pkg::COORD_W-1:0]  x_coord,
	output logic [ntsc_pkg::COORD_W-1:0]  y_coord
);

	import ntsc_pkg::*;

	logic [2:0]         div_cnt;	// 0..4
	logic [COORD_W-1:0] h_cnt;	// ticks within the line
	logic [COORD_W-1:0] line_cnt;	// line within the frame
	logic [COORD_W-1:0] h_next;
	logic [COORD_W-1:0] line_next;
	logic               line_end;
	logic               req_next;	// next count wants a pixel

	// segment decode on a horizontal count
	function automatic line_seg_e seg_of(input logic [COORD_W-1:0] h);
		if (h <= H_SYNC_END)
			return SEG_HSYNC;
		else if (h <= H_BP1_END)
			return SEG_PORCH_A;
		else if (h <= H_BURST_END)
			return SEG_BURST;
		else if (h <= H_BP2_END)
			return SEG_PORCH_B;
		else if (h <= H_ACTIVE_END)
			return SEG_ACTIVE;
		else
			return SEG_FRONT;
	endfunction

	function automatic line_kind_e kind_of(input logic [COORD_W-1:0] ln);
		if (ln < Y_RES)
			return LINE_ACTIVE;
		else if (ln >= VSYNC_FIRST && ln <= VSYNC_LAST)
			return LINE_VSYNC;	// serrated vsync, polarity flipped
		else
			return LINE_BLANK;
	endfunction

	// y is frozen at 0 over the overscan lines
	function automatic logic [COORD_W-1:0] y_of(input logic [COORD_W-1:0] ln);
		if (ln > Y_OFFSET && ln < Y_RES)
			return ln - Y_OFFSET;
		else
			return '0;
	endfunction

	// tick divider, tick is registered so it lands on the 5th clock
	always_ff @(posedge clock_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt    <= '0;
			pixel_tick <= 1'b0;
		end
		else if (div_cnt == TICK_DIV - 3'd1)
		begin
			div_cnt    <= '0;
			pixel_tick <= 1'b1;
		end
		else
		begin
			div_cnt    <= div_cnt + 3'd1;
			pixel_tick <= 1'b0;
		end
	end

	assign line_end  = (h_cnt == H_TOTAL);
	assign h_next    = line_end ? '0 : h_cnt + 10'd1;
	assign line_next = !line_end ? line_cnt :
		(line_cnt == LINE_LAST) ? '0 : line_cnt + 10'd1;	// wrap at end of frame

	assign req_next = (h_next >= X_OFFSET) && (h_next <= H_ACTIVE_END)
		&& (kind_of(line_next) == LINE_ACTIVE);

	// encoder samples these on the tick, before the counts move
	assign seg  = seg_of(h_cnt);
	assign kind = kind_of(line_cnt);

	always_ff @(posedge clock_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt     <= '0;
			line_cnt  <= '0;
			pixel_req <= 1'b0;
			x_coord   <= '0;
			y_coord   <= '0;
		end
		else
		begin
			pixel_req <= pixel_tick && req_next;	// single clock strobe
			if (pixel_tick)
			begin
				h_cnt    <= h_next;
				line_cnt <= line_next;
				if (req_next)
				begin
					x_coord <= h_next - X_OFFSET;	// 0..525
					y_coord <= y_of(line_next);
				end
				else
				begin
					x_coord <= '0;	// outside the window
					y_coord <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/sine_quad_rom.sv */
`default_nettype none

module sine_quad_rom (
	input  logic              [7:0] phase_a,
	input  logic              [7:0] phase_b,
	output logic signed       [7:0] sine_a,
	output logic signed       [7:0] sine_b
);

	// first quadrant, 127 * sin(pi * k / 128) rounded, k = 0..64
	localparam logic [6:0] QUARTER [65] = '{
		7'd0,   7'd3,   7'd6,   7'd9,   7'd12,  7'd16,  7'd19,  7'd22,
		7'd25,  7'd28,  7'd31,  7'd34,  7'd37,  7'd40,  7'd43,  7'd46,
		7'd49,  7'd51,  7'd54,  7'd57,  7'd60,  7'd63,  7'd65,  7'd68,
		7'd71,  7'd73,  7'd76,  7'd78,  7'd81,  7'd83,  7'd85,  7'd88,
		7'd90,  7'd92,  7'd94,  7'd96,  7'd98,  7'd100, 7'd102, 7'd104,
		7'd106, 7'd107, 7'd109, 7'd111, 7'd112, 7'd113, 7'd115, 7'd116,
		7'd117, 7'd118, 7'd120, 7'd121, 7'd122, 7'd122, 7'd123, 7'd124,
		7'd125, 7'd125, 7'd126, 7'd126, 7'd126, 7'd127, 7'd127, 7'd127,
		7'd127
	};

	// fold 256 phases onto the quarter table
	// bit 6 mirrors the index, bit 7 flips the sign
	function automatic logic signed [7:0] fold(input logic [7:0] ph);
		logic [6:0]        idx;
		logic [6:0]        mag;
		logic signed [7:0] pos;
		idx = ph[6] ? (7'd64 - {1'b0, ph[5:0]}) : {1'b0, ph[5:0]};	// 64 reached at 90 deg
		mag = QUARTER[idx];
		pos = {1'b0, mag};
		return ph[7] ? -pos : pos;	// lower half of the wave
	endfunction

	// two independent read ports, purely combinational
	assign sine_a = fold(phase_a);
	assign sine_b = fold(phase_b);

endmodule

`default_nettype wire

/* hdl/subcarrier_dds.sv */
`default_nettype none

module subcarrier_dds (
	input  logic                                clock_in,
	input  logic                                rst_n,
	output logic signed [ntsc_pkg::CHROMA_W-1:0] chroma_u,	// burst phase
	output logic signed [ntsc_pkg::CHROMA_W-1:0] chroma_v	// 90 deg ahead of u
);

	import ntsc_pkg::*;

	localparam logic signed [8:0] SCALE_S = {1'b0, COLOR_SCALE};	// positive, signed multiply

	logic [PHASE_W-1:0] phase_acc;
	logic [7:0]         phase_u;
	logic [7:0]         phase_v;
	logic signed [7:0]  sine_u;
	logic signed [7:0]  sine_v;
	logic signed [15:0] prod_u;	// |127 * 205| fits in 16 bits
	logic signed [15:0] prod_v;

	// free running, never cleared except by reset
	always_ff @(posedge clock_in or negedge rst_n)
	begin
		if (!rst_n)
			phase_acc <= '0;
		else
			phase_acc <= phase_acc + PHASE_STEP;
	end

	assign phase_u = phase_acc[PHASE_W-1:PHASE_W-8];	// top byte addresses the rom
	assign phase_v = phase_u + 8'd64;	// quarter turn

	sine_quad_rom u_sine_rom (
		.phase_a (phase_u),
		.phase_b (phase_v),
		.sine_a  (sine_u),
		.sine_b  (sine_v)
	);

	// saturation scaling
	assign prod_u = sine_u * SCALE_S;
	assign prod_v = sine_v * SCALE_S;

	// keep the top byte, sign extended to 9 bits, about +/-102
	assign chroma_u = {prod_u[15], prod_u[15:8]};
	assign chroma_v = {prod_v[15], prod_v[15:8]};

endmodule

`default_nettype wire

/* hdl/composite_encoder.sv */
`default_nettype none

module composite_encoder (
	input  logic                                 clock_in,
	input  logic                                 rst_n,
	input  logic                                 pixel_tick,
	input  ntsc_pkg::line_seg_e                  seg,
	input  ntsc_pkg::line_kind_e                 kind,
	input  logic [ntsc_pkg::LUMA_W-1:0]          luma,
	input  logic [ntsc_pkg::COLOR_W-1:0]         color,
	input  logic signed [ntsc_pkg::CHROMA_W-1:0] chroma_u,
	input  logic signed [ntsc_pkg::CHROMA_W-1:0] chroma_v,
	output logic [ntsc_pkg::OUT_W-1:0]           composite_out,
	output logic                                 sync_out	// low while at sync tip
);

	import ntsc_pkg::*;

	logic [OUT_W-1:0]   level_q;	// sync / blank / black + luma
	logic               burst_en;
	logic               color_en;
	logic [COLOR_W-1:0] color_q;
	logic [OUT_W-1:0]   u_ext;	// sign extended to dac width
	logic [OUT_W-1:0]   v_ext;
	logic [OUT_W-1:0]   chroma_sel;
	logic [OUT_W-1:0]   burst_term;
	logic [OUT_W-1:0]   color_term;

	// base level for one tick
	function automatic logic [OUT_W-1:0] level_of(
		input line_seg_e         s,
		input line_kind_e        k,
		input logic [LUMA_W-1:0] y
	);
		if (k == LINE_VSYNC)
			return (s == SEG_HSYNC) ? BLANK_LEVEL : SYNC_LEVEL;	// inverted polarity
		else if (s == SEG_HSYNC)
			return SYNC_LEVEL;
		else if (s == SEG_ACTIVE && k == LINE_ACTIVE)
			return BLACK_LEVEL + {1'b0, y};	// max 767, no overflow
		else
			return BLANK_LEVEL;
	endfunction

	// sample segment, line kind and pixel once per tick
	always_ff @(posedge clock_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			level_q  <= SYNC_LEVEL;
			burst_en <= 1'b0;
			color_en <= 1'b0;
		end
		else if (pixel_tick)
		begin
			level_q  <= level_of(seg, kind, luma);
			burst_en <= (seg == SEG_BURST) && (kind != LINE_VSYNC);
			color_en <= (seg == SEG_ACTIVE) && (kind == LINE_ACTIVE);
		end
	end

	// color code travels with the luma sample
	always_ff @(posedge clock_in)
	begin
		if (pixel_tick)
			color_q <= color;
	end

	assign u_ext = {chroma_u[CHROMA_W-1], chroma_u};
	assign v_ext = {chroma_v[CHROMA_W-1], chroma_v};

	// +u, +v, -u, -v per color bit, opposite bits cancel
	always_comb
	begin
		chroma_sel = '0;
		if (color_q[0])
			chroma_sel = chroma_sel + u_ext;
		if (color_q[1])
			chroma_sel = chroma_sel + v_ext;
		if (color_q[2])
			chroma_sel = chroma_sel - u_ext;
		if (color_q[3])
			chroma_sel = chroma_sel - v_ext;
	end

	assign burst_term = burst_en ? u_ext : '0;	// burst is u only
	assign color_term = color_en ? chroma_sel : '0;

	// subcarrier is live, so the sum is registered every clock
	always_ff @(posedge clock_in or negedge rst_n)
	begin
		if (!rst_n)
		begin
			composite_out <= '0;
			sync_out      <= 1'b0;
		end
		else
		begin
			composite_out <= level_q + burst_term + color_term;	// wraps at 10 bits
			sync_out      <= (level_q != SYNC_LEVEL);
		end
	end

endmodule

`default_nettype wire

/* hdl/ntsc_composite_top.sv */
`default_nettype none

module ntsc_composite_top (
	input  logic                          clock_in,	// 50 MHz
	input  logic                          rst_n,
	input  logic [ntsc_pkg::LUMA_W-1:0]   luma,
	input  logic [ntsc_pkg::COLOR_W-1:0]  color,
	output logic                          pixel_req,
	output logic [ntsc_pkg::COORD_W-1:0]  x_coord,
	output logic [ntsc_pkg::COORD_W-1:0]  y_coord,
	output logic [ntsc_pkg::OUT_W-1:0]    composite_out,	// to the dac
	output logic                          sync_out
);

	import ntsc_pkg::*;

	logic                       pixel_tick;
	line_seg_e                  seg;
	line_kind_e                 kind;
	logic signed [CHROMA_W-1:0] chroma_u;
	logic signed [CHROMA_W-1:0] chroma_v;

	// raster counters and pixel requests
	raster_timing u_timing (
		.clock_in   (clock_in),
		.rst_n      (rst_n),
		.pixel_tick (pixel_tick),
		.seg        (seg),
		.kind       (kind),
		.pixel_req  (pixel_req),
		.x_coord    (x_coord),
		.y_coord    (y_coord)
	);

	// color subcarrier, free running from reset
	subcarrier_dds u_dds (
		.clock_in (clock_in),
		.rst_n    (rst_n),
		.chroma_u (chroma_u),
		.chroma_v (chroma_v)
	);

	composite_encoder u_encoder (
		.clock_in      (clock_in),
		.rst_n         (rst_n),
		.pixel_tick    (pixel_tick),
		.seg           (seg),
		.kind          (kind),
		.luma          (luma),
		.color         (color),
		.chroma_u      (chroma_u),
		.chroma_v      (chroma_v),
		.composite_out (composite_out),
		.sync_out      (sync_out)
	);

endmodule

`default_nettype wire

/* sim/tb_ntsc_composite.sv */
`default_nettype none

module tb_ntsc_composite;

	timeunit 1ns;
	timeprecision 1ps;

	import ntsc_pkg::*;

	// raster numbers in pixel ticks and lines
	localparam int H_LAST       = 634;
	localparam int SYNC_LAST    = 46;
	localparam int BURST_FIRST  = 58;
	localparam int BURST_LAST   = 82;
	localparam int ACT_FIRST    = 94;
	localparam int ACT_LAST     = 619;
	localparam int LINES        = 260;	// 240 visible + 20 blanking
	localparam int VIS_LINES    = 240;
	localparam int TOP_LINES    = 17;
	localparam int VS_FIRST     = 246;
	localparam int VS_LAST      = 248;
	localparam int STEP         = 75069;	// subcarrier phase step
	localparam int REQ_PER_LINE = 526;
	localparam longint RUN_CLKS    = 2 * LINES * (H_LAST + 1) * 5;	// two frames
	localparam longint WATCHDOG_NS = RUN_CLKS * 8 * 11 / 10;	// plus 10 %

	logic               clock_in = 1'b0;
	logic               rst_n;
	logic [LUMA_W-1:0]  luma;
	logic [COLOR_W-1:0] color;
	logic               pixel_req;
	logic [COORD_W-1:0] x_coord;
	logic [COORD_W-1:0] y_coord;
	logic [OUT_W-1:0]   composite_out;
	logic               sync_out;

	logic        rst_at_edge;	// rst_n as the dut saw it on the last rising edge
	logic [31:0] lfsr;
	int          sine_tab [256];	// 127 * sin over one full turn

	// reference model state
	int           m_div;
	logic         m_tick;
	int           m_h;
	int           m_line;
	int           m_acc;
	int           m_level;
	logic         m_burst;
	logic         m_color_en;
	logic [3:0]   m_color_q;
	logic [9:0]   m_out;
	logic         m_sync;
	logic         m_req;
	int           m_x;
	int           m_y;
	string        lvl_name;	// kind of tick behind the held level
	string        out_name;
	int           line_reqs;
	int           total_reqs;
	int           frames;
	logic         done;

	ntsc_composite_top u_dut (
		.clock_in      (clock_in),
		.rst_n         (rst_n),
		.luma          (luma),
		.color         (color),
		.pixel_req     (pixel_req),
		.x_coord       (x_coord),
		.y_coord       (y_coord),
		.composite_out (composite_out),
		.sync_out      (sync_out)
	);

	always #4 clock_in = ~clock_in;	// 8 ns period

	always @(posedge clock_in)
		rst_at_edge <= rst_n;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic is_vsync(input int ln);
		return (ln >= VS_FIRST) && (ln <= VS_LAST);
	endfunction

	function automatic logic in_active(input int h, input int ln);
		return (h >= ACT_FIRST) && (h <= ACT_LAST) && (ln < VIS_LINES);
	endfunction

	// level held for one tick
	function automatic int ref_level(input int h, input int ln, input int y);
		if (is_vsync(ln))
			return (h <= SYNC_LAST) ? 205 : 0;	// pulse flips on vsync lines
		else if (h <= SYNC_LAST)
			return 0;
		else if (in_active(h, ln))
			return 256 + y;	// black plus luma
		else
			return 205;
	endfunction

	function automatic int scaled_sine(input int p);
		return (sine_tab[p & 255] * 205) >>> 8;	// floor of the scaled sample
	endfunction

	// expected dac word from the held level, enables and the live phase
	function automatic logic [9:0] ref_composite(input int level, input logic burst,
		input logic col_en, input logic [3:0] code, input int acc);
		int u;
		int v;
		int sum;
		u = scaled_sine(acc >> 12);
		v = scaled_sine((acc >> 12) + 64);	// quarter turn ahead
		sum = level;
		if (burst)
			sum = sum + u;
		if (col_en)
		begin
			if (code[0])
				sum = sum + u;
			if (code[1])
				sum = sum + v;
			if (code[2])
				sum = sum - u;
			if (code[3])
				sum = sum - v;
		end
		return sum[9:0];	// wraps like the 10 bit dac word
	endfunction

	function automatic string name_of(input int h, input int ln);
		if (is_vsync(ln))
			return "vsync_line";
		else if (h <= SYNC_LAST)
			return "hsync";
		else if (h >= BURST_FIRST && h <= BURST_LAST)
			return "burst";
		else if (in_active(h, ln))
			return "active_pixel";
		else
			return "blank_level";
	endfunction

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic compare_word(input string test, input logic [OUT_W-1:0] exp,
		input logic [OUT_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERROR %s expected %0d actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_coord(input string test, input logic [COORD_W-1:0] exp,
		input logic [COORD_W-1:0] act);
		if (act !== exp)
		begin
			$display("ERROR %s expected %0d actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_bit(input string test, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERROR %s expected %0b actual %0b", test, exp, act);
			abort_run();
		end
	endtask

	task automatic build_sine_table();
		real r;
		for (int p = 0; p < 256; p++)
		begin
			r = 127.0 * $sin(3.141592653589793 * p / 128.0);
			sine_tab[p] = (r >= 0.0) ? $rtoi(r + 0.5) : -$rtoi(0.5 - r);	// round half away
		end
	endtask

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);	// one step per bit
			v = {v[30:0], lfsr[31]};
		end
	endtask

	// new random pixel held until the next request
	task automatic drive_pixel();
		logic [31:0] v;
		take_bits(LUMA_W, v);
		luma = v[LUMA_W-1:0];
		take_bits(COLOR_W, v);
		color = v[COLOR_W-1:0];	// includes the self cancelling codes
	endtask

	task automatic reset_model();
		m_div      = 0;
		m_tick     = 1'b0;
		m_h        = 0;
		m_line     = 0;
		m_acc      = 0;
		m_level    = 0;
		m_burst    = 1'b0;
		m_color_en = 1'b0;
		m_color_q  = '0;
		m_out      = '0;
		m_sync     = 1'b0;
		m_req      = 1'b0;
		m_x        = 0;
		m_y        = 0;
		lvl_name   = "reset";
		out_name   = "reset";
		line_reqs  = 0;
		total_reqs = 0;
		frames     = 0;
	endtask

	// one rising edge of the whole subsystem
	task automatic advance_model();
		int h_n;
		int ln_n;
		m_out    = ref_composite(m_level, m_burst, m_color_en, m_color_q, m_acc);
		m_sync   = (m_level != 0);
		out_name = lvl_name;
		m_req    = 1'b0;
		if (m_tick)
		begin
			m_level    = ref_level(m_h, m_line, int'(luma));	// counts before they move
			m_burst    = (m_h >= BURST_FIRST) && (m_h <= BURST_LAST) && !is_vsync(m_line);
			m_color_en = in_active(m_h, m_line);
			m_color_q  = color;
			lvl_name   = name_of(m_h, m_line);
			h_n        = m_h + 1;
			ln_n       = m_line;
			if (m_h == H_LAST)
			begin
				compare_coord("requests_per_line",
					(m_line < VIS_LINES) ? 10'(REQ_PER_LINE) : 10'd0, 10'(line_reqs));
				line_reqs = 0;
				h_n  = 0;
				ln_n = (m_line == LINES - 1) ? 0 : m_line + 1;	// frame wrap
				if (m_line == LINES - 1)
				begin
					frames = frames + 1;
					if (frames == 2)
						done = 1'b1;
				end
			end
			m_req  = in_active(h_n, ln_n);
			m_x    = m_req ? h_n - ACT_FIRST : 0;
			m_y    = (m_req && ln_n > TOP_LINES) ? ln_n - TOP_LINES : 0;
			m_h    = h_n;
			m_line = ln_n;
		end
		m_tick = (m_div == 4);	// tick comes out one clock after the divider end
		m_div  = (m_div == 4) ? 0 : m_div + 1;
		m_acc  = (m_acc + STEP) % 1048576;
	endtask

	// outputs are settled by the falling edge and inputs change here too
	always @(negedge clock_in)
	begin
		if (!rst_at_edge)
		begin
			reset_model();
			compare_word("reset", '0, composite_out);
			compare_bit("reset", 1'b0, pixel_req);
			compare_bit("reset", 1'b0, sync_out);
		end
		else
		begin
			advance_model();
			compare_word(out_name, m_out, composite_out);
			compare_bit(out_name, m_sync, sync_out);
			compare_bit("pixel_request", m_req, pixel_req);
			compare_coord("x_coord", 10'(m_x), x_coord);
			compare_coord("y_coord", 10'(m_y), y_coord);
			if (pixel_req)
			begin
				line_reqs  = line_reqs + 1;
				total_reqs = total_reqs + 1;
				drive_pixel();
			end
		end
	end

	initial
	begin
		rst_n       = 1'b0;
		luma        = '0;
		color       = '0;
		done        = 1'b0;
		lfsr        = 32'h4d53_ef5d;
		build_sine_table();
		reset_model();
		repeat (2) @(negedge clock_in);	// two clocks in reset
		rst_n = 1'b1;
		wait (done);
		if (total_reqs == 2 * VIS_LINES * REQ_PER_LINE && frames == 2)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("pixel request total %0d is wrong for two frames", total_reqs);
			abort_run();
		end
	end

	// two frames plus margin
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before two frames were generated");
		abort_run();
	end

endmodule

`default_nettype wire

/* ntsc_composite_top.f */
hdl/ntsc_pkg.sv
hdl/raster_timing.sv
hdl/sine_quad_rom.sv
hdl/subcarrier_dds.sv
hdl/composite_encoder.sv
hdl/ntsc_composite_top.sv
sim/tb_ntsc_composite.sv

/* Makefile */
TB := tb_ntsc_composite

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status, which fails make
sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TB) \
		-f ntsc_composite_top.f -o $(TB)
	./obj_dir/$(TB)

clean:
	rm -rf obj_dir
